/* ext_bus.f */
logic/ext_bus_pkg.sv
logic/ext_addr_decode.sv
logic/ext_addr_latch.sv
logic/ext_data_port.sv
logic/ext_bus_seq.sv
logic/ext_bus.sv
dv/ext_bus_tb.sv

/* dv/ext_bus_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ext_bus_tb;

	import ext_bus_pkg::*;

	localparam int unsigned SEED    = 40543;
	localparam int PLANNED_XFERS    = 50;
	localparam int CYCLE_LIMIT      = 12 * PLANNED_XFERS + 100;
	localparam int XFER_CYCLES      = ADDR_SETUP_CYCLES + STROBE_CYCLES + 1;	// start to ack.

	logic        clk;
	logic        arst_n;
	logic        cpu_req;
	bus_req_t    cpu_cmd;
	logic        cpu_ack;
	logic        dma_req;
	logic [15:0] dma_addr;
	logic        dma_ack;
	logic [7:0]  rdata;
	logic [7:0]  pin_rdata;
	pin_bus_t    pins;

	logic [7:0]  mem [0:65535];
	logic [7:0]  mem_at_cur;
	logic        busy;
	logic        xfer_open;
	logic        ack_any;
	logic        owner_req;
	logic        start;
	logic [15:0] req_addr;
	logic        req_write;
	logic [15:0] cur_addr;
	logic [7:0]  cur_wdata;
	logic [7:0]  cur_rdata;
	logic        cur_write;
	logic        cur_dma;
	logic        exp_a15;
	logic        exp_cs_n;
	int          cycle_cnt = 0;
	int          err_cnt = 0;
	int          err_mark = 0;
	int          tests_run = 0;
	int          tests_bad = 0;

	ext_bus dut_i (.*);

	always #50 clk = ~clk;

	function automatic logic is_rom(input logic [15:0] a);
		return a <= 16'h7FFF;
	endfunction

	function automatic logic is_cart_ram(input logic [15:0] a);
		return (a >= 16'hA000) && (a <= 16'hFDFF);
	endfunction

	function automatic logic is_external(input logic [15:0] a);
		return is_rom(a) || is_cart_ram(a);
	endfunction

	function automatic logic [15:0] pick_external_addr();
		if ($urandom_range(1, 0) == 0) begin
			return 16'($urandom_range(16'h7FFF, 16'h0000));
		end
		return 16'($urandom_range(16'hFDFF, 16'hA000));
	endfunction

	assign ack_any    = cpu_ack || dma_ack;
	assign req_addr   = dma_req ? dma_addr : cpu_cmd.addr;	// dma wins a tie.
	assign req_write  = !dma_req && cpu_cmd.write;
	assign start      = !busy && !ack_any && (cpu_req || dma_req);
	assign xfer_open  = busy && !ack_any;
	assign owner_req  = cur_dma ? dma_req : cpu_req;
	assign exp_a15    = !(xfer_open && is_rom(cur_addr));
	assign exp_cs_n   = !(xfer_open && is_cart_ram(cur_addr));
	assign mem_at_cur = mem[cur_addr];
	assign pin_rdata  = pins.rd_n ? 8'h00 : mem[pins.addr];	// cartridge answers under rd_n.

	// the byte on the pins when wr_n rises is the one that stays.
	always @(posedge clk) begin
		if (!pins.wr_n) begin
			mem[pins.addr] <= pins.wdata;
		end
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			cur_addr  <= '0;
			cur_wdata <= '0;
			cur_rdata <= '0;
			cur_write <= 1'b0;
			cur_dma   <= 1'b0;
		end else if (start) begin
			busy      <= 1'b1;
			cur_addr  <= req_addr;
			cur_wdata <= cpu_cmd.wdata;
			cur_rdata <= mem[req_addr];
			cur_write <= req_write;
			cur_dma   <= dma_req;
		end else if (ack_any) begin
			busy <= 1'b0;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles", cycle_cnt);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic flag_mismatch(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		err_cnt++;
		$display("FAILED %s: got %0h, expected %0h at %0t", name, got, exp, $time);
	endtask

	task automatic report_problem(input string what);
		err_cnt++;
		$display("error at %0t: %s", $time, what);
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (err_cnt == err_mark) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_bad++;
			$display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_mark);
		end
		err_mark = err_cnt;
	endtask

	task automatic cpu_transfer(input logic [15:0] addr, input logic [7:0] wdata,
			input logic write, input int hold);
		@(negedge clk);
		cpu_cmd.addr  = addr;
		cpu_cmd.wdata = wdata;
		cpu_cmd.write = write;
		cpu_req       = 1'b1;
		do begin
			@(negedge clk);
		end while (!cpu_ack);
		repeat (hold) @(negedge clk);	// keeps ack up.
		cpu_req = 1'b0;
		do begin
			@(negedge clk);
		end while (cpu_ack);
	endtask

	task automatic dma_transfer(input logic [15:0] addr, input int hold);
		@(negedge clk);
		dma_addr = addr;
		dma_req  = 1'b1;
		do begin
			@(negedge clk);
		end while (!dma_ack);
		repeat (hold) @(negedge clk);
		dma_req = 1'b0;
		do begin
			@(negedge clk);
		end while (dma_ack);
	endtask

	a_reset_idle: assert property (@(posedge clk)
		!arst_n |-> pins.rd_n && pins.wr_n && pins.cs_n && !pins.data_oe
			&& !cpu_ack && !dma_ack && pins.addr[15])
		else report_problem("bus not idle while reset is asserted");

	a_ext_timing: assert property (@(posedge clk) disable iff (!arst_n)
		start && is_external(req_addr) |-> ##1 (pins.rd_n && pins.wr_n)[*ADDR_SETUP_CYCLES]
			##1 (!(pins.rd_n && pins.wr_n))[*STROBE_CYCLES]
			##1 (pins.rd_n && pins.wr_n && ack_any))
		else report_problem("strobe or ack out of place on an external transfer");

	a_int_timing: assert property (@(posedge clk) disable iff (!arst_n)
		start && !is_external(req_addr) |-> ##1 (pins.rd_n && pins.wr_n && !ack_any)
			[*ADDR_SETUP_CYCLES] ##1 (pins.rd_n && pins.wr_n && ack_any))
		else report_problem("internal transfer strobed the pins or acked late");

	a_strobe_kind: assert property (@(posedge clk) disable iff (!arst_n)
		!(!pins.rd_n && cur_write) && !(!pins.wr_n && !cur_write))
		else report_problem("wrong strobe for the transfer direction");

	a_ext_rdata: assert property (@(posedge clk) disable iff (!arst_n)
		start && is_external(req_addr) && !req_write |-> ##XFER_CYCLES rdata == cur_rdata)
		else flag_mismatch("rdata", $sampled(rdata), $sampled(cur_rdata));

	a_int_rdata: assert property (@(posedge clk) disable iff (!arst_n)
		start && !is_external(req_addr) && !req_write |->
			##(ADDR_SETUP_CYCLES + 1) rdata == OPEN_BUS_DATA)
		else flag_mismatch("rdata", $sampled(rdata), OPEN_BUS_DATA);

	a_wdata_model: assert property (@(posedge clk) disable iff (!arst_n)
		start && is_external(req_addr) && req_write |-> ##XFER_CYCLES mem_at_cur == cur_wdata)
		else flag_mismatch("mem", $sampled(mem_at_cur), $sampled(cur_wdata));

	a_data_oe: assert property (@(posedge clk) disable iff (!arst_n)
		pins.data_oe == !pins.wr_n)
		else flag_mismatch("pins.data_oe", $sampled(pins.data_oe), !$sampled(pins.wr_n));

	a_addr_low: assert property (@(posedge clk) disable iff (!arst_n)
		pins.addr[14:0] == cur_addr[14:0])
		else flag_mismatch("pins.addr", $sampled(pins.addr), $sampled(cur_addr));

	a_addr_a15: assert property (@(posedge clk) disable iff (!arst_n)
		pins.addr[15] == exp_a15)
		else flag_mismatch("pins.addr[15]", $sampled(pins.addr[15]), $sampled(exp_a15));

	a_cs: assert property (@(posedge clk) disable iff (!arst_n)
		pins.cs_n == exp_cs_n)
		else flag_mismatch("pins.cs_n", $sampled(pins.cs_n), $sampled(exp_cs_n));

	a_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		!xfer_open |-> pins.rd_n && pins.wr_n)
		else report_problem("strobe outside a transfer");

	a_ack_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(cpu_ack && dma_ack))
		else report_problem("cpu_ack and dma_ack high together");

	a_ack_owner: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack_any) |-> dma_ack == cur_dma && cpu_ack == !cur_dma)
		else report_problem("ack went to the wrong requester");

	a_ack_follow: assert property (@(posedge clk) disable iff (!arst_n)
		ack_any |=> ack_any == $past(owner_req))
		else report_problem("ack did not follow its req");

	initial begin
		logic [15:0] addr;
		void'($urandom(SEED));
		clk      = 1'b0;
		arst_n   = 1'b0;
		cpu_req  = 1'b0;
		cpu_cmd  = '0;
		dma_req  = 1'b0;
		dma_addr = '0;
		for (int i = 0; i < 65536; i++) begin
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		repeat (2) @(negedge clk);
		close_test("reset");

		for (int i = 0; i < 8; i++) begin
			addr = pick_external_addr();
			cpu_transfer(addr, 8'($urandom), 1'b1, 0);
			cpu_transfer(addr, 8'h00, 1'b0, 0);	// read back.
		end
		close_test("cpu external read and write");

		cpu_transfer(16'h0000, 8'h00, 1'b0, 0);
		cpu_transfer(16'h7FFF, 8'hC3, 1'b1, 0);
		cpu_transfer(16'hA000, 8'h00, 1'b0, 0);
		cpu_transfer(16'hFDFF, 8'h96, 1'b1, 0);
		cpu_transfer(16'h7FFF, 8'h00, 1'b0, 0);
		cpu_transfer(16'hFDFF, 8'h00, 1'b0, 0);
		close_test("address pins");

		cpu_transfer(16'h8000, 8'h00, 1'b0, 0);
		cpu_transfer(16'h9FFF, 8'h11, 1'b1, 0);
		cpu_transfer(16'hFE00, 8'h00, 1'b0, 0);
		cpu_transfer(16'hFFFF, 8'h00, 1'b0, 0);
		for (int i = 0; i < 4; i++) begin
			addr = i[0] ? 16'($urandom_range(16'hFFFF, 16'hFE00))
				: 16'($urandom_range(16'h9FFF, 16'h8000));
			cpu_transfer(addr, 8'($urandom), 1'($urandom_range(1, 0)), 0);
		end
		close_test("non-external regions");

		for (int i = 0; i < 6; i++) begin
			dma_transfer(16'($urandom), 0);
		end
		for (int i = 0; i < 4; i++) begin
			fork
				cpu_transfer(pick_external_addr(), 8'($urandom), 1'($urandom_range(1, 0)), 0);
				dma_transfer(16'($urandom), 0);
			join
		end
		close_test("dma");

		cpu_transfer(16'h0123, 8'h00, 1'b0, 3);
		cpu_transfer(16'hB456, 8'h3C, 1'b1, 2);
		for (int i = 0; i < 2; i++) begin
			fork
				dma_transfer(pick_external_addr(), 4);
				begin
					repeat (2) @(negedge clk);
					cpu_transfer(pick_external_addr(), 8'($urandom), 1'b0, 0);
				end
			join
		end
		close_test("four-phase handshake");

		$display("%0d tests, %0d with errors, %0d errors", tests_run, tests_bad, err_cnt);
		if (err_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/ext_bus.sv */
`timescale 1ns/100ps
`default_nettype none

module ext_bus (
	input  wire logic                  clk,
	input  wire logic                  arst_n,
	input  wire logic                  cpu_req,
	input  wire ext_bus_pkg::bus_req_t cpu_cmd,
	output logic                       cpu_ack,
	input  wire logic                  dma_req,
	input  wire logic [15:0]           dma_addr,
	output logic                       dma_ack,
	output logic [7:0]                 rdata,
	input  wire logic [7:0]            pin_rdata,
	output ext_bus_pkg::pin_bus_t      pins
);

	import ext_bus_pkg::*;

	addr_info_t  info;
	logic        sel_dma;
	logic        capture;
	logic        active;
	logic        rd_phase;
	logic        wr_phase;
	logic        rd_n;
	logic        wr_n;
	logic        cs_n;
	logic        data_oe;
	logic [15:0] held_addr;
	logic [15:0] pin_addr;
	logic [7:0]  pin_wdata;

	ext_bus_seq seq_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.cpu_req   (cpu_req),
		.cpu_write (cpu_cmd.write),
		.dma_req   (dma_req),
		.info      (info),
		.cpu_ack   (cpu_ack),
		.dma_ack   (dma_ack),
		.sel_dma   (sel_dma),
		.capture   (capture),
		.active    (active),
		.rd_phase  (rd_phase),
		.wr_phase  (wr_phase),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.cs_n      (cs_n)
	);

	ext_addr_latch latch_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.cpu_addr  (cpu_cmd.addr),
		.dma_addr  (dma_addr),
		.sel_dma   (sel_dma),
		.capture   (capture),
		.active    (active),
		.info      (info),
		.held_addr (held_addr),
		.pin_addr  (pin_addr)
	);

	ext_addr_decode decode_i (
		.addr (held_addr),
		.info (info)
	);

	ext_data_port data_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.wdata     (cpu_cmd.wdata),
		.pin_rdata (pin_rdata),
		.rd_phase  (rd_phase),
		.wr_phase  (wr_phase),
		.external  (info.external),
		.pin_wdata (pin_wdata),
		.data_oe   (data_oe),
		.rdata     (rdata)
	);

	assign pins.addr    = pin_addr;
	assign pins.wdata   = pin_wdata;
	assign pins.data_oe = data_oe;
	assign pins.rd_n    = rd_n;
	assign pins.wr_n    = wr_n;
	assign pins.cs_n    = cs_n;

endmodule

`default_nettype wire

/* logic/ext_bus_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module ext_bus_seq (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire logic                    cpu_req,
	input  wire logic                    cpu_write,
	input  wire logic                    dma_req,
	input  wire ext_bus_pkg::addr_info_t info,
	output logic                         cpu_ack,
	output logic                         dma_ack,
	output logic                         sel_dma,
	output logic                         capture,
	output logic                         active,
	output logic                         rd_phase,
	output logic                         wr_phase,
	output logic                         rd_n,
	output logic                         wr_n,
	output logic                         cs_n
);

	import ext_bus_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		SETUP,
		STROBE,
		DONE,
		RELEASE
	} state_e;

	state_e               state;
	state_e               state_nxt;
	logic [SEQ_CNT_W-1:0] cnt;
	logic                 grant_dma;	// owner of the transfer.
	logic                 write_q;
	logic                 owner_req;
	logic                 setup_end;
	logic                 strobe_end;
	logic                 acking;

	assign owner_req  = grant_dma ? dma_req : cpu_req;
	assign setup_end  = (cnt == SEQ_CNT_W'(ADDR_SETUP_CYCLES - 1));
	assign strobe_end = (cnt == SEQ_CNT_W'(STROBE_CYCLES - 1));

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (dma_req || cpu_req) begin
					state_nxt = SETUP;
				end
			end
			SETUP: begin
				if (setup_end) begin
					state_nxt = info.external ? STROBE : DONE;	// internal regions skip the pins.
				end
			end
			STROBE: begin
				if (strobe_end) begin
					state_nxt = DONE;
				end
			end
			DONE, RELEASE: begin
				state_nxt = owner_req ? RELEASE : IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			cnt       <= '0;
			grant_dma <= 1'b0;
			write_q   <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state_nxt != state || !active) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			if (capture) begin
				grant_dma <= dma_req;	// dma wins a tie.
				write_q   <= !dma_req && cpu_write;
			end
		end
	end

	assign capture = (state == IDLE) && (dma_req || cpu_req);
	assign sel_dma = (state == IDLE) ? dma_req : grant_dma;
	assign active  = (state == SETUP) || (state == STROBE);
	assign acking  = (state == DONE) || (state == RELEASE);

	assign cpu_ack = acking && !grant_dma;
	assign dma_ack = acking && grant_dma;

	// internal reads still pass a read phase so open bus data gets loaded.
	assign rd_phase = !write_q && ((state == STROBE) || (state == SETUP && !info.external));
	assign wr_phase = write_q && (state == STROBE);

	assign rd_n = !((state == STROBE) && !write_q);
	assign wr_n = !wr_phase;
	assign cs_n = !(active && info.chip_sel);

	a_cpu_ack_req: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(cpu_ack) |-> $past(cpu_req)
	);

	a_dma_ack_req: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(dma_ack) |-> $past(dma_req)
	);

	a_ack_excl: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(cpu_ack && dma_ack)
	);

	a_strobe_excl: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(!rd_n && !wr_n)
	);

endmodule

`default_nettype wire

/* logic/ext_data_port.sv */
`timescale 1ns/100ps
`default_nettype none

module ext_data_port (
	input  wire logic       clk,
	input  wire logic       arst_n,
	input  wire logic [7:0] wdata,
	input  wire logic [7:0] pin_rdata,
	input  wire logic       rd_phase,
	input  wire logic       wr_phase,
	input  wire logic       external,
	output logic [7:0]      pin_wdata,
	output logic            data_oe,
	output logic [7:0]      rdata
);

	import ext_bus_pkg::*;

	logic [7:0] rd_sample;

	// follow the requester until the write strobe, then hold.
	always_ff @(posedge clk) begin
		if (!wr_phase) begin
			pin_wdata <= wdata;
		end
	end

	assign data_oe = wr_phase;	// drivers on only under wr_n.

	assign rd_sample = external ? pin_rdata : OPEN_BUS_DATA;

	// last sample is taken on the edge that ends rd_phase.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rdata <= OPEN_BUS_DATA;
		end else if (rd_phase) begin
			rdata <= rd_sample;
		end
	end

	a_phase_excl: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(rd_phase && wr_phase)
	);

endmodule

`default_nettype wire

/* logic/ext_addr_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module ext_addr_latch (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire logic [15:0]             cpu_addr,
	input  wire logic [15:0]             dma_addr,
	input  wire logic                    sel_dma,
	input  wire logic                    capture,
	input  wire logic                    active,
	input  wire ext_bus_pkg::addr_info_t info,
	output logic [15:0]                  held_addr,
	output logic [15:0]                  pin_addr
);

	import ext_bus_pkg::*;

	logic [15:0] src_addr;
	logic        rom_cycle;

	assign src_addr = sel_dma ? dma_addr : cpu_addr;

	// the bus keeps the last address until the next transfer.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			held_addr <= '0;
		end else if (capture) begin
			held_addr <= src_addr;
		end
	end

	assign rom_cycle = active && (info.region == REGION_ROM);

	// a15 doubles as the rom select, so it only drops during a rom access.
	assign pin_addr[15]   = held_addr[15] | ~rom_cycle;
	assign pin_addr[14:0] = held_addr[14:0];

	a_capture_idle: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(capture) |-> !active
	);

endmodule

`default_nettype wire

/* logic/ext_addr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module ext_addr_decode (
	input  wire logic [15:0]             addr,
	output ext_bus_pkg::addr_info_t      info
);

	import ext_bus_pkg::*;

	region_e region;
	logic    external;
	logic    chip_sel;

	always_comb begin
		if (addr < VRAM_BASE) begin
			region = REGION_ROM;
		end else if (addr < EXTRAM_BASE) begin
			region = REGION_VRAM;	// video ram has its own bus.
		end else if (addr < HIGH_BASE) begin
			region = REGION_EXTRAM;	// echo area decodes here too.
		end else begin
			region = REGION_HIGH;
		end
	end

	assign external = (region == REGION_ROM) || (region == REGION_EXTRAM);
	assign chip_sel = (region == REGION_EXTRAM);

	assign info.region   = region;
	assign info.external = external;
	assign info.chip_sel = chip_sel;

endmodule

`default_nettype wire

/* logic/ext_bus_pkg.sv */
`default_nettype none

package ext_bus_pkg;

	// cartridge side memory map.
	localparam logic [15:0] VRAM_BASE   = 16'h8000;
	localparam logic [15:0] EXTRAM_BASE = 16'hA000;
	localparam logic [15:0] HIGH_BASE   = 16'hFE00;

	localparam int ADDR_SETUP_CYCLES = 1;	// address before strobe.
	localparam int STROBE_CYCLES     = 2;	// rd_n / wr_n low time.
	localparam int SEQ_CNT_W         = 2;	// wide enough for both phases.

	localparam logic [7:0] OPEN_BUS_DATA = 8'hFF;	// nothing drives the bus.

	typedef enum logic [1:0] {
		REGION_ROM    = 2'd0,
		REGION_VRAM   = 2'd1,
		REGION_EXTRAM = 2'd2,
		REGION_HIGH   = 2'd3
	} region_e;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        write;
	} bus_req_t;

	typedef struct packed {
		region_e region;
		logic    external;	// goes out on the cartridge pins.
		logic    chip_sel;	// cartridge ram select.
	} addr_info_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        data_oe;
		logic        rd_n;
		logic        wr_n;
		logic        cs_n;
	} pin_bus_t;

endpackage

`default_nettype wire
